// File: mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// tlb geometry.
`define TLB_ENTRIES 4
`define PAGE_SHIFT 12

// cycles the internal reset stays low after aresetn rises.
`define RESET_HOLD_CYCLES 16

// apb register offsets.
`define APB_ENTRY_HI 4'h0
`define APB_ENTRY_LO 4'h4
`define APB_INDEX 4'h8

// entry_lo flag bits.
`define ENTRY_LO_DIRTY 1
`define ENTRY_LO_VALID 0

`endif

// File: mmu_pkg.sv
`default_nettype none

`include "mmu_consts.svh"

package mmu_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    typedef logic [31-`PAGE_SHIFT:0] vpn_t; // virtual page number.
    typedef logic [31-`PAGE_SHIFT:0] pfn_t; // physical frame number.
    typedef logic [$clog2(`TLB_ENTRIES)-1:0] tlb_idx_t;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADDR_ERR,    // word access not aligned.
        EXC_TLB_MISS,
        EXC_TLB_INVALID,
        EXC_TLB_MOD,     // store to a clean page.
        EXC_BUS_ERR
    } exc_code_t;

endpackage

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef logic [3:0] apb_addr_t; // register offset.
    typedef logic [1:0] axi_resp_t;

    typedef enum logic [2:0] {
        AXI_IDLE,
        AXI_AR,
        AXI_R,
        AXI_AW_W, // address and data channels run in parallel.
        AXI_B,
        AXI_RSP
    } axi_state_t;

endpackage

`default_nettype wire

// File: mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if import mmu_pkg::*; ();

    logic      valid;
    paddr_t    paddr;
    logic      write;
    word_t     wdata;
    strb_t     wstrb;
    exc_code_t exc;   // non-zero items skip the bus.
    logic      ready;

    modport src (
        output valid, paddr, write, wdata, wstrb, exc,
        input  ready
    );

    modport dst (
        input  valid, paddr, write, wdata, wstrb, exc,
        output ready
    );

endinterface

`default_nettype wire

// File: tlb_write_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tlb_write_if import mmu_pkg::*; ();

    logic     we; // one cycle per entry write.
    tlb_idx_t idx;
    vpn_t     vpn;
    pfn_t     pfn;
    logic     valid;
    logic     dirty;

    modport src (
        output we, idx, vpn, pfn, valid, dirty
    );

    modport dst (
        input  we, idx, vpn, pfn, valid, dirty
    );

endinterface

`default_nettype wire

// File: tlb_cfg_apb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_consts.svh"

module tlb_cfg_apb import mmu_pkg::*, bus_pkg::*; (
    input  wire logic  aclk,
    input  wire logic  aresetn,

    input  wire logic  i_psel,
    input  wire logic  i_penable,
    input  wire logic  i_pwrite,
    input  apb_addr_t  i_paddr,
    input  word_t      i_pwdata,
    output word_t      o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,

    tlb_write_if.src   tlb_wr
);

    word_t    entry_hi;
    word_t    entry_lo;
    logic     we_q;
    tlb_idx_t idx_q;
    logic     access;
    logic     addr_ok;

    assign access  = i_psel && i_penable;
    assign addr_ok = (i_paddr == `APB_ENTRY_HI) || (i_paddr == `APB_ENTRY_LO) ||
                     (i_paddr == `APB_INDEX);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            entry_hi <= '0;
            entry_lo <= '0;
            we_q     <= 1'b0;
            idx_q    <= '0;
        end else begin
            we_q <= 1'b0;
            if (access && i_pwrite) begin
                case (i_paddr)
                    `APB_ENTRY_HI: entry_hi <= i_pwdata;
                    `APB_ENTRY_LO: entry_lo <= i_pwdata;
                    `APB_INDEX: begin
                        we_q  <= 1'b1; // commit the staged entry.
                        idx_q <= i_pwdata[$bits(tlb_idx_t)-1:0];
                    end
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (i_paddr)
            `APB_ENTRY_HI: o_prdata = entry_hi;
            `APB_ENTRY_LO: o_prdata = entry_lo;
            default:       o_prdata = '0; // index is write only.
        endcase
    end

    assign o_pready  = 1'b1;
    assign o_pslverr = access && !addr_ok;

    // staging registers cannot change before the pulse is consumed.
    assign tlb_wr.we    = we_q;
    assign tlb_wr.idx   = idx_q;
    assign tlb_wr.vpn   = entry_hi[31:`PAGE_SHIFT];
    assign tlb_wr.pfn   = entry_lo[31:`PAGE_SHIFT];
    assign tlb_wr.dirty = entry_lo[`ENTRY_LO_DIRTY];
    assign tlb_wr.valid = entry_lo[`ENTRY_LO_VALID];

endmodule

`default_nettype wire

// File: tlb_translate.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_consts.svh"

module tlb_translate import mmu_pkg::*; (
    input  wire logic aclk,
    input  wire logic i_rst_n,

    input  wire logic i_req_valid,
    input  wire logic i_req_write,
    input  vaddr_t    i_req_addr,
    input  word_t     i_req_wdata,
    input  strb_t     i_req_wstrb,
    output logic      o_req_ready,

    tlb_write_if.dst  tlb_wr,
    mem_req_if.src    req
);

    vpn_t                   tlb_vpn [`TLB_ENTRIES];
    pfn_t                   tlb_pfn [`TLB_ENTRIES];
    logic [`TLB_ENTRIES-1:0] tlb_dirty;
    logic [`TLB_ENTRIES-1:0] tlb_valid;

    vpn_t      req_vpn;
    logic      unmapped;
    logic      hit;
    tlb_idx_t  hit_idx;
    exc_code_t next_exc;
    paddr_t    next_paddr;

    logic      run_q;
    logic      accept;
    logic      slot_valid;
    paddr_t    slot_paddr;
    logic      slot_write;
    word_t     slot_wdata;
    strb_t     slot_wstrb;
    exc_code_t slot_exc;

    always_ff @(posedge aclk) begin
        if (tlb_wr.we) begin
            tlb_vpn[tlb_wr.idx]   <= tlb_wr.vpn;
            tlb_pfn[tlb_wr.idx]   <= tlb_wr.pfn;
            tlb_dirty[tlb_wr.idx] <= tlb_wr.dirty;
        end
    end

    // entries programmed during the reset hold are kept.
    always_ff @(posedge aclk) begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (tlb_wr.we && (tlb_wr.idx == tlb_idx_t'(i))) begin
                tlb_valid[i] <= tlb_wr.valid;
            end else if (!i_rst_n) begin
                tlb_valid[i] <= 1'b0;
            end
        end
    end

    assign req_vpn  = i_req_addr[31:`PAGE_SHIFT];
    assign unmapped = (i_req_addr[31:30] == 2'b10);

    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin // lowest index wins.
            if (tlb_vpn[i] == req_vpn) begin
                hit     = 1'b1;
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    always_comb begin
        next_exc   = EXC_NONE;
        next_paddr = {3'b000, i_req_addr[28:0]};
        if (i_req_addr[1:0] != 2'b00) begin
            next_exc = EXC_ADDR_ERR;
        end else if (!unmapped) begin
            next_paddr = {tlb_pfn[hit_idx], i_req_addr[`PAGE_SHIFT-1:0]};
            if (!hit) begin
                next_exc = EXC_TLB_MISS;
            end else if (!tlb_valid[hit_idx]) begin
                next_exc = EXC_TLB_INVALID;
            end else if (i_req_write && !tlb_dirty[hit_idx]) begin
                next_exc = EXC_TLB_MOD;
            end
        end
    end

    assign o_req_ready = run_q && (!slot_valid || req.ready);
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            run_q      <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (accept) begin
                slot_valid <= 1'b1;
            end else if (req.ready) begin
                slot_valid <= 1'b0; // item taken by the master.
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            slot_paddr <= next_paddr;
            slot_write <= i_req_write;
            slot_wdata <= i_req_wdata;
            slot_wstrb <= i_req_wstrb;
            slot_exc   <= next_exc;
        end
    end

    assign req.valid = slot_valid;
    assign req.paddr = slot_paddr;
    assign req.write = slot_write;
    assign req.wdata = slot_wdata;
    assign req.wstrb = slot_wstrb;
    assign req.exc   = slot_exc;

endmodule

`default_nettype wire

// File: axi_lite_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_lite_master import mmu_pkg::*, bus_pkg::*; (
    input  wire logic aclk,
    input  wire logic i_rst_n,

    mem_req_if.dst    req,

    output logic      o_rsp_valid,
    output word_t     o_rsp_rdata,
    output exc_code_t o_rsp_exc,

    output paddr_t    o_araddr,
    output logic      o_arvalid,
    input  wire logic i_arready,
    input  word_t     i_rdata,
    input  axi_resp_t i_rresp,
    input  wire logic i_rvalid,
    output logic      o_rready,

    output paddr_t    o_awaddr,
    output logic      o_awvalid,
    input  wire logic i_awready,
    output word_t     o_wdata,
    output strb_t     o_wstrb,
    output logic      o_wvalid,
    input  wire logic i_wready,
    input  axi_resp_t i_bresp,
    input  wire logic i_bvalid,
    output logic      o_bready
);

    axi_state_t state;
    logic       aw_pend;
    logic       w_pend;
    logic       take;
    logic       aw_fire;
    logic       w_fire;
    paddr_t     addr_q;
    word_t      wdata_q;
    strb_t      wstrb_q;
    word_t      rsp_rdata_q;
    exc_code_t  rsp_exc_q;

    assign req.ready = (state == AXI_IDLE);
    assign take      = req.valid && req.ready;
    assign aw_fire   = aw_pend && i_awready;
    assign w_fire    = w_pend && i_wready;

    always_ff @(posedge aclk) begin
        if (!i_rst_n) begin
            state   <= AXI_IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            case (state)
                AXI_IDLE: begin
                    if (take) begin
                        if (req.exc != EXC_NONE) begin
                            state <= AXI_RSP;
                        end else if (req.write) begin
                            state   <= AXI_AW_W;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end else begin
                            state <= AXI_AR;
                        end
                    end
                end
                AXI_AR: if (i_arready) state <= AXI_R;
                AXI_R:  if (i_rvalid) state <= AXI_RSP;
                AXI_AW_W: begin
                    if (aw_fire) aw_pend <= 1'b0;
                    if (w_fire) w_pend <= 1'b0;
                    if ((aw_fire || !aw_pend) && (w_fire || !w_pend)) begin
                        state <= AXI_B;
                    end
                end
                AXI_B:   if (i_bvalid) state <= AXI_RSP;
                default: state <= AXI_IDLE; // response cycle.
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (take) begin
            addr_q      <= req.paddr;
            wdata_q     <= req.wdata;
            wstrb_q     <= req.wstrb;
            rsp_rdata_q <= '0;
            rsp_exc_q   <= req.exc;
        end else if ((state == AXI_R) && i_rvalid) begin
            rsp_rdata_q <= (i_rresp != '0) ? '0 : i_rdata;
            rsp_exc_q   <= (i_rresp != '0) ? EXC_BUS_ERR : EXC_NONE;
        end else if ((state == AXI_B) && i_bvalid) begin
            rsp_exc_q <= (i_bresp != '0) ? EXC_BUS_ERR : EXC_NONE;
        end
    end

    assign o_araddr  = addr_q;
    assign o_arvalid = (state == AXI_AR);
    assign o_rready  = (state == AXI_R);
    assign o_awaddr  = addr_q;
    assign o_awvalid = aw_pend;
    assign o_wdata   = wdata_q;
    assign o_wstrb   = wstrb_q;
    assign o_wvalid  = w_pend;
    assign o_bready  = (state == AXI_B);

    assign o_rsp_valid = (state == AXI_RSP);
    assign o_rsp_rdata = rsp_rdata_q;
    assign o_rsp_exc   = rsp_exc_q;

endmodule

`default_nettype wire

// File: mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_consts.svh"

module mmu_top import mmu_pkg::*, bus_pkg::*; (
    input  wire logic aclk,
    input  wire logic aresetn,

    input  wire logic i_req_valid,
    output logic      o_req_ready,
    input  wire logic i_req_write,
    input  vaddr_t    i_req_addr,
    input  word_t     i_req_wdata,
    input  strb_t     i_req_wstrb,

    output logic      o_rsp_valid,
    output word_t     o_rsp_rdata,
    output exc_code_t o_rsp_exc,

    input  wire logic i_psel,
    input  wire logic i_penable,
    input  wire logic i_pwrite,
    input  apb_addr_t i_paddr,
    input  word_t     i_pwdata,
    output word_t     o_prdata,
    output logic      o_pready,
    output logic      o_pslverr,

    output paddr_t    o_araddr,
    output logic      o_arvalid,
    input  wire logic i_arready,
    input  word_t     i_rdata,
    input  axi_resp_t i_rresp,
    input  wire logic i_rvalid,
    output logic      o_rready,

    output paddr_t    o_awaddr,
    output logic      o_awvalid,
    input  wire logic i_awready,
    output word_t     o_wdata,
    output strb_t     o_wstrb,
    output logic      o_wvalid,
    input  wire logic i_wready,
    input  axi_resp_t i_bresp,
    input  wire logic i_bvalid,
    output logic      o_bready
);

    localparam int HOLD_W = $clog2(`RESET_HOLD_CYCLES);

    logic [HOLD_W-1:0] hold_cnt;
    logic              hold_done;
    logic              core_rst_n;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_done <= 1'b0;
            hold_cnt  <= '0;
        end else if (!hold_done) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == HOLD_W'(`RESET_HOLD_CYCLES - 1)) begin
                hold_done <= 1'b1; // data path leaves reset.
            end
        end
    end

    assign core_rst_n = aresetn && hold_done;

    tlb_write_if tlb_wr_bus ();
    mem_req_if   req_bus ();

    tlb_cfg_apb u_cfg (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .tlb_wr    (tlb_wr_bus.src)
    );

    tlb_translate u_xlat (
        .aclk        (aclk),
        .i_rst_n     (core_rst_n),
        .i_req_valid (i_req_valid),
        .i_req_write (i_req_write),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .i_req_wstrb (i_req_wstrb),
        .o_req_ready (o_req_ready),
        .tlb_wr      (tlb_wr_bus.dst),
        .req         (req_bus.src)
    );

    axi_lite_master u_axi (
        .aclk        (aclk),
        .i_rst_n     (core_rst_n),
        .req         (req_bus.dst),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_rdata (o_rsp_rdata),
        .o_rsp_exc   (o_rsp_exc),
        .o_araddr    (o_araddr),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_rdata     (i_rdata),
        .i_rresp     (i_rresp),
        .i_rvalid    (i_rvalid),
        .o_rready    (o_rready),
        .o_awaddr    (o_awaddr),
        .o_awvalid   (o_awvalid),
        .i_awready   (i_awready),
        .o_wdata     (o_wdata),
        .o_wstrb     (o_wstrb),
        .o_wvalid    (o_wvalid),
        .i_wready    (i_wready),
        .i_bresp     (i_bresp),
        .i_bvalid    (i_bvalid),
        .o_bready    (o_bready)
    );

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_mem (
    input  wire logic        aclk,
    input  wire logic        aresetn,

    input  wire logic [31:0] i_araddr,
    input  wire logic        i_arvalid,
    output logic             o_arready,
    output logic [31:0]      o_rdata,
    output logic [1:0]       o_rresp,
    output logic             o_rvalid,
    input  wire logic        i_rready,

    input  wire logic [31:0] i_awaddr,
    input  wire logic        i_awvalid,
    output logic             o_awready,
    input  wire logic [31:0] i_wdata,
    input  wire logic [3:0]  i_wstrb,
    input  wire logic        i_wvalid,
    output logic             o_wready,
    output logic [1:0]       o_bresp,
    output logic             o_bvalid,
    input  wire logic        i_bready
);

    logic [31:0] mem [256];
    integer      seed;
    int          ar_wait;
    int          aw_wait;
    int          w_wait;
    logic        aw_got;
    logic        w_got;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [3:0]  w_strb;

    function automatic int stall_cycles();
        return int'($unsigned($random(seed)) % 4); // 0 to 3 cycles.
    endfunction

    function automatic logic [1:0] resp_for(input logic [31:0] addr);
        return (addr[31:28] == 4'hF) ? 2'b10 : 2'b00; // slverr region.
    endfunction

    initial begin
        seed = 32'h2800cf37;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'hA5, i[7:0], ~i[7:0], i[7:0]};
        end
    end

    always @(posedge aclk) begin
        if (!aresetn) begin
            o_arready <= 1'b0;
            o_rvalid  <= 1'b0;
            o_rdata   <= '0;
            o_rresp   <= '0;
            o_awready <= 1'b0;
            o_wready  <= 1'b0;
            o_bvalid  <= 1'b0;
            o_bresp   <= '0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
            ar_wait   <= stall_cycles();
            aw_wait   <= stall_cycles();
            w_wait    <= stall_cycles();
        end else begin
            if (o_arready) begin
                o_arready <= 1'b0;
                o_rvalid  <= 1'b1;
                o_rresp   <= resp_for(i_araddr);
                o_rdata   <= (resp_for(i_araddr) != 2'b00) ? '0 : mem[i_araddr[9:2]];
                ar_wait   <= stall_cycles();
            end else if (i_arvalid) begin
                if (ar_wait == 0) o_arready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
            if (o_rvalid && i_rready) o_rvalid <= 1'b0;

            if (o_awready) begin
                o_awready <= 1'b0;
                aw_got    <= 1'b1;
                aw_addr   <= i_awaddr;
                aw_wait   <= stall_cycles();
            end else if (i_awvalid && !aw_got) begin
                if (aw_wait == 0) o_awready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end

            if (o_wready) begin
                o_wready <= 1'b0;
                w_got    <= 1'b1;
                w_data   <= i_wdata;
                w_strb   <= i_wstrb;
                w_wait   <= stall_cycles();
            end else if (i_wvalid && !w_got) begin
                if (w_wait == 0) o_wready <= 1'b1;
                else w_wait <= w_wait - 1;
            end

            if (aw_got && w_got) begin
                aw_got   <= 1'b0;
                w_got    <= 1'b0;
                o_bvalid <= 1'b1;
                o_bresp  <= resp_for(aw_addr);
                if (resp_for(aw_addr) == 2'b00) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb[b]) mem[aw_addr[9:2]][8*b +: 8] <= w_data[8*b +: 8];
                    end
                end
            end
            if (o_bvalid && i_bready) o_bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb_mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mmu_consts.svh"

module tb_mmu_top import mmu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 250 * 24 + 1000;

    logic aclk;
    logic aresetn;
    logic req_valid, req_ready, req_write;
    logic [31:0] req_addr, req_wdata;
    logic [3:0] req_wstrb;
    logic rsp_valid;
    logic [31:0] rsp_rdata;
    exc_code_t rsp_exc;
    logic psel, penable, pwrite, pready, pslverr;
    logic [3:0] paddr;
    logic [31:0] pwdata, prdata;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic [1:0] rresp, bresp;
    logic [3:0] wstrb;

    logic [19:0] ref_vpn [4];
    logic [19:0] ref_pfn [4];
    logic [3:0]  ref_valid;
    logic [3:0]  ref_dirty;
    logic [31:0] shadow [256];
    logic [34:0] exp_q [$];
    integer      seed;
    int          cycles;

    mmu_top dut0 (
        .aclk(aclk), .aresetn(aresetn),
        .i_req_valid(req_valid), .o_req_ready(req_ready), .i_req_write(req_write),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata), .i_req_wstrb(req_wstrb),
        .o_rsp_valid(rsp_valid), .o_rsp_rdata(rsp_rdata), .o_rsp_exc(rsp_exc),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
        .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
        .o_araddr(araddr), .o_arvalid(arvalid), .i_arready(arready), .i_rdata(rdata),
        .i_rresp(rresp), .i_rvalid(rvalid), .o_rready(rready),
        .o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready), .o_wdata(wdata),
        .o_wstrb(wstrb), .o_wvalid(wvalid), .i_wready(wready), .i_bresp(bresp),
        .i_bvalid(bvalid), .o_bready(bready)
    );

    tb_axi_mem mem0 (
        .aclk(aclk), .aresetn(aresetn),
        .i_araddr(araddr), .i_arvalid(arvalid), .o_arready(arready), .o_rdata(rdata),
        .o_rresp(rresp), .o_rvalid(rvalid), .i_rready(rready),
        .i_awaddr(awaddr), .i_awvalid(awvalid), .o_awready(awready), .i_wdata(wdata),
        .i_wstrb(wstrb), .i_wvalid(wvalid), .o_wready(wready), .o_bresp(bresp),
        .o_bvalid(bvalid), .i_bready(bready)
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_stop($sformatf("error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // expected {exc, rdata} from the address rules; stores update the shadow memory.
    function automatic logic [34:0] predict(input logic wr, input logic [31:0] addr,
                                            input logic [31:0] data, input logic [3:0] strb);
        exc_code_t   exc;
        logic [31:0] pa;
        logic [31:0] rd;
        int          hit;
        exc = EXC_NONE;
        pa  = {3'b000, addr[28:0]};
        rd  = '0;
        hit = -1;
        if (addr[1:0] != 2'b00) begin
            exc = EXC_ADDR_ERR;
        end else if (addr[31:30] != 2'b10) begin
            for (int i = 3; i >= 0; i--) begin
                if (ref_vpn[i] == addr[31:12]) hit = i;
            end
            if (hit < 0) exc = EXC_TLB_MISS;
            else if (!ref_valid[hit]) exc = EXC_TLB_INVALID;
            else if (wr && !ref_dirty[hit]) exc = EXC_TLB_MOD;
            else pa = {ref_pfn[hit], addr[11:0]};
        end
        if (exc == EXC_NONE) begin
            if (pa[31:28] == 4'hF) begin
                exc = EXC_BUS_ERR;
            end else if (wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) shadow[pa[9:2]][8*b +: 8] = data[8*b +: 8];
                end
            end else begin
                rd = shadow[pa[9:2]];
            end
        end
        return {exc, rd};
    endfunction

    always @(posedge aclk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) fail_stop("timeout: responses did not arrive in time");
    end

    // responses are stable over the low phase.
    always @(negedge aclk) begin
        logic [34:0] exp;
        if (aresetn && rsp_valid) begin
            if (exp_q.size() == 0) fail_stop("response arrived with no request outstanding");
            exp = exp_q.pop_front();
            check_value("o_rsp_exc", 32'(rsp_exc), 32'(exp[34:32]));
            check_value("o_rsp_rdata", rsp_rdata, exp[31:0]);
        end
    end

    task automatic send_req(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_wdata = data;
        req_wstrb = strb;
        while (!req_ready) @(negedge aclk);
        @(negedge aclk);
        exp_q.push_back(predict(wr, addr, data, strb));
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge aclk);
        @(negedge aclk);
    endtask

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output logic [31:0] rd, output logic err);
        psel    = 1'b1;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge aclk);
        penable = 1'b1;
        @(negedge aclk);
        check_value("o_pready", 32'(pready), 32'h1);
        rd      = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic tlb_program(input int idx, input logic [19:0] vpn, input logic [19:0] pfn,
                               input logic v, input logic d);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, `APB_ENTRY_HI, {vpn, 12'h0}, rd, err);
        apb_access(1'b1, `APB_ENTRY_LO, {pfn, 10'h0, d, v}, rd, err);
        apb_access(1'b0, `APB_ENTRY_HI, '0, rd, err);
        check_value("entry_hi", rd, {vpn, 12'h0});
        apb_access(1'b0, `APB_ENTRY_LO, '0, rd, err);
        check_value("entry_lo", rd, {pfn, 10'h0, d, v});
        check_value("o_pslverr", 32'(err), 32'h0);
        apb_access(1'b1, `APB_INDEX, 32'(idx), rd, err);
        @(negedge aclk); // entry lands one cycle after the index access.
        ref_vpn[idx]   = vpn;
        ref_pfn[idx]   = pfn;
        ref_valid[idx] = v;
        ref_dirty[idx] = d;
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [31:0] base;
        seed = 32'h2800cf37;
        cycles = 0;
        aresetn = 1'b0;
        {req_valid, req_write, req_addr, req_wdata, req_wstrb} = '0;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        for (int i = 0; i < 256; i++) shadow[i] = {8'hA5, i[7:0], ~i[7:0], i[7:0]};
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (`RESET_HOLD_CYCLES) begin
            check_value("o_req_ready", 32'(req_ready), 32'h0);
            @(negedge aclk);
        end

        send_req(1'b1, 32'h8000_0100, 32'h1122_3344, 4'hF);
        send_req(1'b1, 32'h8000_0100, 32'hAABB_CCDD, 4'b0101);
        send_req(1'b0, 32'h8000_0100, '0, 4'h0);
        send_req(1'b0, 32'hA000_0100, '0, 4'h0);
        drain();

        tlb_program(0, 20'h00400, 20'h00001, 1'b1, 1'b1);
        tlb_program(1, 20'h00400, 20'h00002, 1'b0, 1'b1); // shadowed by entry 0.
        tlb_program(2, 20'h00500, 20'h00003, 1'b1, 1'b0);
        tlb_program(3, 20'h00600, 20'hF0000, 1'b1, 1'b1);
        send_req(1'b1, 32'h0040_0020, 32'hCAFE_F00D, 4'hF);
        send_req(1'b0, 32'h0040_0020, '0, 4'h0);
        send_req(1'b0, 32'h8000_1020, '0, 4'h0);
        send_req(1'b0, 32'h0040_0022, '0, 4'h0);
        send_req(1'b1, 32'h0090_0000, 32'h1, 4'hF);
        send_req(1'b1, 32'h0050_0020, 32'h2, 4'hF);
        send_req(1'b0, 32'h0050_0020, '0, 4'h0);
        send_req(1'b0, 32'h8000_1000, '0, 4'h0);
        send_req(1'b1, 32'h0060_0040, 32'h3, 4'hF);
        send_req(1'b0, 32'h0060_0040, '0, 4'h0);
        drain();
        tlb_program(1, 20'h00700, 20'h00004, 1'b0, 1'b1);
        send_req(1'b1, 32'h0070_0010, 32'h4, 4'hF);
        send_req(1'b0, 32'h8000_3020, '0, 4'h0);
        drain();

        for (int n = 0; n < 200; n++) begin
            case ($unsigned($random(seed)) % 6)
                0: base = 32'h8000_0000;
                1: base = 32'h0040_0000;
                2: base = 32'h0050_0000;
                3: base = 32'h0060_0000;
                4: base = 32'h0070_0000;
                default: base = $random(seed);
            endcase
            base = base | ($random(seed) & 32'h3FC);
            send_req(1'(($random(seed)) & 1), base, $random(seed), 4'($random(seed)));
        end
        drain();

        apb_access(1'b0, 4'hC, '0, rd, err);
        check_value("o_pslverr", 32'(err), 32'h1);
        apb_access(1'b1, 4'h2, 32'h5, rd, err);
        check_value("o_pslverr", 32'(err), 32'h1);

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
mmu_pkg.sv
bus_pkg.sv
mem_req_if.sv
tlb_write_if.sv
tlb_cfg_apb.sv
tlb_translate.sv
axi_lite_master.sv
mmu_top.sv
tb_axi_mem.sv
tb_mmu_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module tb_mmu_top -o tb_mmu_top_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/tb_mmu_top_sim 2>&1)
status=$?
echo "$output"

if echo "$output" | grep -q '^>>> PASS$'; then
    exit 0
fi
echo "simulation exited with status $status"
exit 1
